//--- tb.f
+incdir+common
common/axi_bridge_pkg.sv
axil_reflect/axil_reflect_wr.sv
axil_reflect/axil_reflect_rd.sv
src/axil_reg_bank.sv
src/axi_reg_subsys.sv
verif/axi_reg_subsys_chk.sv
verif/axi_reg_subsys_tb.sv

//--- verif/axi_reg_subsys_tb.sv
`include "axi_bridge_consts.svh"

module axi_reg_subsys_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import axi_bridge_pkg::*;

  localparam int TIMEOUT = 1000;

  logic                   clk;
  logic                   rst_n;
  axi_ax_t                aw;
  axi_ax_t                ar;
  axi_w_t                 w;
  axi_b_t                 b;
  axi_r_t                 r;
  logic                   awvalid;
  logic                   awready;
  logic                   wvalid;
  logic                   wready;
  logic                   bvalid;
  logic                   bready;
  logic                   arvalid;
  logic                   arready;
  logic                   rvalid;
  logic                   rready;
  logic [`AXI_DATA_W-1:0] model [`REG_COUNT];
  axi_b_t                 exp_b [$];
  axi_r_t                 exp_r [$];
  axi_b_t                 b_exp;
  axi_r_t                 r_exp;
  logic [31:0]            lfsr_q;
  logic [31:0]            stall_q;
  logic                   stall_en;
  logic                   stall_now;

  axi_reg_subsys axi_reg_subsys_i (.*);

  always #50 clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] apply_strobe(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < `AXI_STRB_W; i++) begin
      if (strb[i]) res[8*i +: 8] = data[8*i +: 8];
    end
    return res;
  endfunction

  function automatic axi_resp_e addr_resp(input logic [15:0] addr);
    return (addr / 4 < `REG_COUNT) ? OKAY : DECERR;
  endfunction

  function automatic logic [31:0] read_value(input logic [15:0] addr);
    return (addr_resp(addr) == OKAY) ? model[addr / 4] : '0;
  endfunction

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp) else begin
      $display("FAILED %s: expected %h, got %h", name, exp, got);
      $display("Done: errors found");
      $fatal(1);
    end
  endtask

  // Returns 1 ns after the edge where both signals were high
  task automatic wait_handshake(ref logic valid, ref logic ready, input string what);
    int n;
    n = 0;
    @(posedge clk);
    while (!(valid === 1'b1 && ready === 1'b1)) begin
      n++;
      if (n > TIMEOUT) fail_now({"Timeout: the ", what, " handshake never completed"});
      @(posedge clk);
    end
    #1;
  endtask

  task automatic do_write(input logic [15:0] addr, input logic [31:0] data, input logic [3:0] strb,
                          input logic [3:0] id, input logic [1:0] user, input logic [7:0] len);
    axi_resp_e resp;
    resp = (len != 8'd0) ? SLVERR : addr_resp(addr);
    if (resp == OKAY) model[addr / 4] = apply_strobe(model[addr / 4], data, strb);
    exp_b.push_back(axi_b_t'{id: id, resp: resp, user: user});
    aw = '{id: id, addr: addr, len: len, user: user};
    awvalid = 1'b1;
    w = '{data: data, strb: strb, last: (len == 8'd0)};
    wvalid = 1'b1;
    wait_handshake(awvalid, awready, "AW");
    awvalid = 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
      w.last = (i == int'(len));
      wait_handshake(wvalid, wready, "W");
    end
    wvalid = 1'b0;
  endtask

  task automatic do_read(input logic [15:0] addr, input logic [3:0] id, input logic [1:0] user,
                         input logic [7:0] len);
    if (len == 8'd0) begin
      exp_r.push_back(axi_r_t'{id: id, data: read_value(addr), resp: addr_resp(addr),
                               last: 1'b1, user: user});
    end else begin
      for (int i = 0; i <= int'(len); i++) begin
        exp_r.push_back(axi_r_t'{id: id, data: '0, resp: SLVERR, last: (i == int'(len)),
                                 user: user});
      end
    end
    ar = '{id: id, addr: addr, len: len, user: user};
    arvalid = 1'b1;
    wait_handshake(arvalid, arready, "AR");
    arvalid = 1'b0;
  endtask

  task automatic read_back_all();
    for (int i = 0; i < `REG_COUNT; i++) begin
      do_read(16'(i * 4), 4'(rand_bits(4)), 2'(rand_bits(2)), 8'd0);
    end
  endtask

  task automatic drain_responses();
    int n;
    n = 0;
    while (exp_b.size() != 0 || exp_r.size() != 0) begin
      n++;
      if (n > TIMEOUT) fail_now("Timeout: responses still outstanding at the end of a phase");
      @(posedge clk);
      #1;
    end
  endtask

  always @(posedge clk) begin  // Stalls only in the back-pressure phase
    stall_now = stall_en;
    #1;
    if (stall_now) begin
      stall_q = lfsr_step(stall_q);
      bready  = stall_q[0];
      stall_q = lfsr_step(stall_q);
      rready  = stall_q[0];
    end else begin
      bready = 1'b1;
      rready = 1'b1;
    end
  end

  always @(posedge clk) begin
    if (rst_n === 1'b1 && bvalid === 1'b1 && bready === 1'b1) begin
      if (exp_b.size() == 0) begin
        fail_now("A B response arrived with no write outstanding");
      end else begin
        b_exp = exp_b.pop_front();
        check_value("b.id", b_exp.id, b.id);
        check_value("b.resp", b_exp.resp, b.resp);
        check_value("b.user", b_exp.user, b.user);
      end
    end
    if (rst_n === 1'b1 && rvalid === 1'b1 && rready === 1'b1) begin
      if (exp_r.size() == 0) begin
        fail_now("An R beat arrived with no read outstanding");
      end else begin
        r_exp = exp_r.pop_front();
        check_value("r.id", r_exp.id, r.id);
        check_value("r.data", r_exp.data, r.data);
        check_value("r.resp", r_exp.resp, r.resp);
        check_value("r.last", r_exp.last, r.last);
        check_value("r.user", r_exp.user, r.user);
      end
    end
  end

  initial begin
    logic [15:0] addr;
    logic [15:0] raddr;
    clk      = 1'b0;
    rst_n    = 1'b0;
    aw       = '0;
    ar       = '0;
    w        = '0;
    awvalid  = 1'b0;
    wvalid   = 1'b0;
    arvalid  = 1'b0;
    bready   = 1'b1;
    rready   = 1'b1;
    stall_en = 1'b0;
    lfsr_q   = 32'he045b77b;
    stall_q  = 32'he045b77b;
    for (int i = 0; i < `REG_COUNT; i++) begin
      model[i] = '0;
    end

    @(posedge clk);
    #1;
    check_value("awready", 0, awready);
    check_value("wready", 0, wready);
    check_value("arready", 0, arready);
    check_value("bvalid", 0, bvalid);
    check_value("rvalid", 0, rvalid);
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    wait_handshake(awready, arready, "awready and arready rise after reset, the");

    for (int i = 0; i < 24; i++) begin
      do_write(16'(4 * rand_bits(4)), rand_bits(32), 4'(rand_bits(4)), 4'(rand_bits(4)),
               2'(rand_bits(2)), 8'd0);
    end
    read_back_all();

    for (int i = 0; i < 4; i++) begin
      do_write(16'd64 + 16'(rand_bits(12)), rand_bits(32), 4'hf, 4'(rand_bits(4)),
               2'(rand_bits(2)), 8'd0);
      do_read(16'd64 + 16'(rand_bits(12)), 4'(rand_bits(4)), 2'(rand_bits(2)), 8'd0);
    end
    read_back_all();

    for (int len = 1; len <= 3; len++) begin
      do_write(16'(4 * rand_bits(4)), rand_bits(32), 4'hf, 4'(rand_bits(4)),
               2'(rand_bits(2)), 8'(len));
      do_read(16'(4 * rand_bits(4)), 4'(rand_bits(4)), 2'(rand_bits(2)), 8'(len));
    end
    read_back_all();
    drain_responses();

    stall_en = 1'b1;
    for (int i = 0; i < 12; i++) begin
      addr = 16'(4 * rand_bits(4));
      do_write(addr, rand_bits(32), 4'(rand_bits(4)), 4'(rand_bits(4)), 2'(rand_bits(2)), 8'd0);
      do_read(addr, 4'(rand_bits(4)), 2'(rand_bits(2)), 8'd0);
    end
    drain_responses();
    stall_en = 1'b0;

    addr  = 16'(4 * rand_bits(4));
    raddr = addr ^ 16'h0004;  // Neighbouring register, never the written one
    fork
      do_write(addr, 32'h5a5a_c3c3, 4'hf, 4'h9, 2'h1, 8'd0);
      do_read(raddr, 4'h6, 2'h2, 8'd0);
    join
    drain_responses();
    read_back_all();
    drain_responses();

    if (axi_reg_subsys_i.chk_i.fail_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Bound checker reported %0d assertion failures", axi_reg_subsys_i.chk_i.fail_cnt);
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- verif/axi_reg_subsys_chk.sv
module axi_reg_subsys_chk (
  input logic                         clk,
  input logic                         rst_n,
  input logic                         awvalid,
  input logic                         awready,
  input axi_bridge_pkg::axi_b_t       b,
  input logic                         bvalid,
  input logic                         bready,
  input axi_bridge_pkg::axi_r_t       r,
  input logic                         rvalid,
  input logic                         rready
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;  // Read by the testbench at the end of the run

  b_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (bvalid && !bready) |=> (bvalid && $stable(b)))
    else begin
      $error("B payload or bvalid changed while stalled");
      fail_cnt++;
    end

  r_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (rvalid && !rready) |=> (rvalid && $stable(r)))
    else begin
      $error("R payload or rvalid changed while stalled");
      fail_cnt++;
    end

  // Synchronous reset clears the valids one edge later
  reset_quiet: assert property (@(posedge clk) !rst_n |=> (!bvalid && !rvalid))
    else begin
      $error("bvalid or rvalid high during reset");
      fail_cnt++;
    end

  aw_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid |-> !(awvalid && awready))
    else begin
      $error("AW accepted while a B response is pending");
      fail_cnt++;
    end

endmodule

bind axi_reg_subsys axi_reg_subsys_chk chk_i (
  .clk     (clk),
  .rst_n   (rst_n),
  .awvalid (awvalid),
  .awready (awready),
  .b       (b),
  .bvalid  (bvalid),
  .bready  (bready),
  .r       (r),
  .rvalid  (rvalid),
  .rready  (rready)
);

//--- src/axi_reg_subsys.sv
`include "axi_bridge_consts.svh"

module axi_reg_subsys (
  input  logic                         clk,
  input  logic                         rst_n,
  input  axi_bridge_pkg::axi_ax_t      aw,
  input  logic                         awvalid,
  output logic                         awready,
  input  axi_bridge_pkg::axi_w_t       w,
  input  logic                         wvalid,
  output logic                         wready,
  output axi_bridge_pkg::axi_b_t       b,
  output logic                         bvalid,
  input  logic                         bready,
  input  axi_bridge_pkg::axi_ax_t      ar,
  input  logic                         arvalid,
  output logic                         arready,
  output axi_bridge_pkg::axi_r_t       r,
  output logic                         rvalid,
  input  logic                         rready
);
  import axi_bridge_pkg::*;

  // Internal AXI-Lite link between the reflectors and the bank
  logic [`AXI_ADDR_W-1:0] lite_awaddr;
  logic                   lite_awvalid;
  logic                   lite_awready;
  axil_w_t                lite_w;
  logic                   lite_wvalid;
  logic                   lite_wready;
  axi_resp_e              lite_bresp;
  logic                   lite_bvalid;
  logic                   lite_bready;
  logic [`AXI_ADDR_W-1:0] lite_araddr;
  logic                   lite_arvalid;
  logic                   lite_arready;
  axil_r_t                lite_r;
  logic                   lite_rvalid;
  logic                   lite_rready;

  axil_reflect_wr wr_reflect_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .s_aw      (aw),
    .s_awvalid (awvalid),
    .s_awready (awready),
    .s_w       (w),
    .s_wvalid  (wvalid),
    .s_wready  (wready),
    .s_b       (b),
    .s_bvalid  (bvalid),
    .s_bready  (bready),
    .m_awaddr  (lite_awaddr),
    .m_awvalid (lite_awvalid),
    .m_awready (lite_awready),
    .m_w       (lite_w),
    .m_wvalid  (lite_wvalid),
    .m_wready  (lite_wready),
    .m_bresp   (lite_bresp),
    .m_bvalid  (lite_bvalid),
    .m_bready  (lite_bready)
  );

  axil_reflect_rd rd_reflect_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .s_ar      (ar),
    .s_arvalid (arvalid),
    .s_arready (arready),
    .s_r       (r),
    .s_rvalid  (rvalid),
    .s_rready  (rready),
    .m_araddr  (lite_araddr),
    .m_arvalid (lite_arvalid),
    .m_arready (lite_arready),
    .m_r       (lite_r),
    .m_rvalid  (lite_rvalid),
    .m_rready  (lite_rready)
  );

  axil_reg_bank #(
    .NUM_REGS (`REG_COUNT)
  ) reg_bank_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (lite_awaddr),
    .awvalid (lite_awvalid),
    .awready (lite_awready),
    .w       (lite_w),
    .wvalid  (lite_wvalid),
    .wready  (lite_wready),
    .bresp   (lite_bresp),
    .bvalid  (lite_bvalid),
    .bready  (lite_bready),
    .araddr  (lite_araddr),
    .arvalid (lite_arvalid),
    .arready (lite_arready),
    .r       (lite_r),
    .rvalid  (lite_rvalid),
    .rready  (lite_rready)
  );

endmodule

//--- src/axil_reg_bank.sv
`include "axi_bridge_consts.svh"

module axil_reg_bank #(
  parameter int NUM_REGS = `REG_COUNT
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [`AXI_ADDR_W-1:0]       awaddr,
  input  logic                         awvalid,
  output logic                         awready,
  input  axi_bridge_pkg::axil_w_t      w,
  input  logic                         wvalid,
  output logic                         wready,
  output axi_bridge_pkg::axi_resp_e    bresp,
  output logic                         bvalid,
  input  logic                         bready,
  input  logic [`AXI_ADDR_W-1:0]       araddr,
  input  logic                         arvalid,
  output logic                         arready,
  output axi_bridge_pkg::axil_r_t      r,
  output logic                         rvalid,
  input  logic                         rready
);
  import axi_bridge_pkg::*;

  localparam int IDX_W = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

  logic [`AXI_DATA_W-1:0] regs [NUM_REGS];
  logic                   b_valid_q;
  axi_resp_e              b_resp_q;
  logic                   r_valid_q;
  logic [`AXI_DATA_W-1:0] r_data_q;
  axi_resp_e              r_resp_q;
  logic                   wr_fire;
  logic                   rd_fire;
  logic                   wr_hit;
  logic                   rd_hit;
  logic [IDX_W-1:0]       wr_idx;
  logic [IDX_W-1:0]       rd_idx;

  // Word index is the byte address over four, the range check uses all of it
  function automatic logic word_in_range(input logic [`AXI_ADDR_W-1:0] addr);
    return addr[`AXI_ADDR_W-1:2] < NUM_REGS;
  endfunction

  assign wr_hit = word_in_range(awaddr);
  assign rd_hit = word_in_range(araddr);
  assign wr_idx = awaddr[IDX_W+1:2];
  assign rd_idx = araddr[IDX_W+1:2];

  // AW and W are taken together, only when no B is waiting
  assign awready = awvalid && wvalid && !b_valid_q;
  assign wready  = awready;
  assign arready = arvalid && !r_valid_q;
  assign wr_fire = awvalid && awready;
  assign rd_fire = arvalid && arready;

  assign bvalid = b_valid_q;
  assign bresp  = b_resp_q;
  assign rvalid = r_valid_q;
  assign r      = '{data: r_data_q, resp: r_resp_q};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_fire && wr_hit) begin
      for (int b = 0; b < `AXI_STRB_W; b++) begin
        if (w.strb[b]) regs[wr_idx][8*b +: 8] <= w.data[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      b_valid_q <= 1'b0;
    end else if (wr_fire) begin
      b_valid_q <= 1'b1;
    end else if (bready) begin
      b_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_valid_q <= 1'b0;
    end else if (rd_fire) begin
      r_valid_q <= 1'b1;
    end else if (rready) begin
      r_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) b_resp_q <= wr_hit ? OKAY : DECERR;
    if (rd_fire) begin
      r_data_q <= rd_hit ? regs[rd_idx] : '0;  // Unmapped reads return zero
      r_resp_q <= rd_hit ? OKAY : DECERR;
    end
  end

endmodule

//--- axil_reflect/axil_reflect_rd.sv
`include "axi_bridge_consts.svh"

module axil_reflect_rd (
  input  logic                         clk,
  input  logic                         rst_n,
  input  axi_bridge_pkg::axi_ax_t      s_ar,
  input  logic                         s_arvalid,
  output logic                         s_arready,
  output axi_bridge_pkg::axi_r_t       s_r,
  output logic                         s_rvalid,
  input  logic                         s_rready,
  output logic [`AXI_ADDR_W-1:0]       m_araddr,
  output logic                         m_arvalid,
  input  logic                         m_arready,
  input  axi_bridge_pkg::axil_r_t      m_r,
  input  logic                         m_rvalid,
  output logic                         m_rready
);
  import axi_bridge_pkg::*;

  rd_state_e              state;
  logic                   ar_ready_q;
  logic                   lite_ar_q;
  logic                   r_valid_q;
  logic [7:0]             beats_q;   // Beats left after the one on the bus
  logic [`AXI_ID_W-1:0]   id_q;
  logic [`AXI_USER_W-1:0] user_q;
  logic [`AXI_ADDR_W-1:0] addr_q;
  logic [`AXI_DATA_W-1:0] data_q;
  axi_resp_e              resp_q;
  logic                   ar_fire;
  logic                   lite_r_fire;

  assign ar_fire     = s_arvalid && ar_ready_q;
  assign lite_r_fire = m_rvalid && m_rready;

  assign s_arready = ar_ready_q;
  assign m_araddr  = addr_q;
  assign m_arvalid = lite_ar_q;
  assign m_rready  = (state == RD_LITE_DATA);
  assign s_rvalid  = r_valid_q;

  always_comb begin
    s_r.id   = id_q;
    s_r.data = data_q;
    s_r.resp = resp_q;
    s_r.last = (state != RD_ERR_BEATS) || (beats_q == 8'd0);
    s_r.user = user_q;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= RD_IDLE;
      ar_ready_q <= 1'b0;
      lite_ar_q  <= 1'b0;
      r_valid_q  <= 1'b0;
      beats_q    <= 8'd0;
    end else begin
      case (state)
        RD_IDLE: begin
          ar_ready_q <= !ar_fire;
          if (ar_fire) begin
            beats_q <= s_ar.len;
            if (s_ar.len == 8'd0) begin
              state     <= RD_FWD;
              lite_ar_q <= 1'b1;
            end else begin
              state     <= RD_ERR_BEATS;
              r_valid_q <= 1'b1;
            end
          end
        end
        RD_FWD: begin
          if (m_arready) begin
            state     <= RD_LITE_DATA;
            lite_ar_q <= 1'b0;
          end
        end
        RD_LITE_DATA: begin
          if (m_rvalid) begin
            state     <= RD_RESP;
            r_valid_q <= 1'b1;
          end
        end
        RD_RESP: begin
          if (s_rready) begin
            state      <= RD_IDLE;
            r_valid_q  <= 1'b0;
            ar_ready_q <= 1'b1;
          end
        end
        RD_ERR_BEATS: begin
          if (s_rready) begin
            if (beats_q == 8'd0) begin
              state      <= RD_IDLE;
              r_valid_q  <= 1'b0;
              ar_ready_q <= 1'b1;
            end else begin
              beats_q <= beats_q - 8'd1;
            end
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      id_q   <= s_ar.id;
      user_q <= s_ar.user;
      addr_q <= s_ar.addr;
      data_q <= '0;      // Burst error beats carry zero data
      resp_q <= SLVERR;
    end else if (lite_r_fire) begin
      data_q <= m_r.data;
      resp_q <= m_r.resp;
    end
  end

endmodule

//--- axil_reflect/axil_reflect_wr.sv
`include "axi_bridge_consts.svh"

module axil_reflect_wr (
  input  logic                         clk,
  input  logic                         rst_n,
  input  axi_bridge_pkg::axi_ax_t      s_aw,
  input  logic                         s_awvalid,
  output logic                         s_awready,
  input  axi_bridge_pkg::axi_w_t       s_w,
  input  logic                         s_wvalid,
  output logic                         s_wready,
  output axi_bridge_pkg::axi_b_t       s_b,
  output logic                         s_bvalid,
  input  logic                         s_bready,
  output logic [`AXI_ADDR_W-1:0]       m_awaddr,
  output logic                         m_awvalid,
  input  logic                         m_awready,
  output axi_bridge_pkg::axil_w_t      m_w,
  output logic                         m_wvalid,
  input  logic                         m_wready,
  input  axi_bridge_pkg::axi_resp_e    m_bresp,
  input  logic                         m_bvalid,
  output logic                         m_bready
);
  import axi_bridge_pkg::*;

  wr_state_e              state;
  logic                   aw_ready_q;
  logic                   lite_aw_q;
  logic                   lite_w_q;
  logic                   b_valid_q;
  logic [`AXI_ID_W-1:0]   id_q;
  logic [`AXI_USER_W-1:0] user_q;
  logic [`AXI_ADDR_W-1:0] addr_q;
  axi_resp_e              resp_q;
  logic                   aw_fire;
  logic                   m_aw_fire;
  logic                   m_w_fire;
  logic                   drain_last;

  assign aw_fire    = s_awvalid && aw_ready_q;
  assign m_aw_fire  = lite_aw_q && m_awready;
  assign m_w_fire   = m_wvalid && m_wready;
  assign drain_last = (state == WR_DRAIN) && s_wvalid && s_w.last;

  assign s_awready = aw_ready_q;
  assign m_awaddr  = addr_q;
  assign m_awvalid = lite_aw_q;
  assign m_w       = '{data: s_w.data, strb: s_w.strb};  // Beat passes straight through
  assign m_wvalid  = lite_w_q && s_wvalid;
  assign s_wready  = (lite_w_q && m_wready) || (state == WR_DRAIN);
  assign m_bready  = (state == WR_LITE_RESP);
  assign s_bvalid  = b_valid_q;
  assign s_b       = '{id: id_q, resp: resp_q, user: user_q};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= WR_IDLE;
      aw_ready_q <= 1'b0;
      lite_aw_q  <= 1'b0;
      lite_w_q   <= 1'b0;
      b_valid_q  <= 1'b0;
    end else begin
      case (state)
        WR_IDLE: begin
          aw_ready_q <= !aw_fire;
          if (aw_fire) begin
            if (s_aw.len == 8'd0) begin
              state     <= WR_FWD;
              lite_aw_q <= 1'b1;
              lite_w_q  <= 1'b1;
            end else begin
              state <= WR_DRAIN;  // Bursts are never forwarded
            end
          end
        end
        WR_FWD: begin
          if (m_aw_fire) lite_aw_q <= 1'b0;
          if (m_w_fire) lite_w_q <= 1'b0;
          if ((!lite_aw_q || m_aw_fire) && (!lite_w_q || m_w_fire)) state <= WR_LITE_RESP;
        end
        WR_LITE_RESP: begin
          if (m_bvalid) begin
            state     <= WR_RESP;
            b_valid_q <= 1'b1;
          end
        end
        WR_DRAIN: begin
          if (drain_last) begin
            state     <= WR_RESP;
            b_valid_q <= 1'b1;
          end
        end
        WR_RESP: begin
          if (s_bready) begin
            state      <= WR_IDLE;
            b_valid_q  <= 1'b0;
            aw_ready_q <= 1'b1;
          end
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      id_q   <= s_aw.id;
      user_q <= s_aw.user;
      addr_q <= s_aw.addr;
    end
    if (m_bvalid && m_bready) resp_q <= m_bresp;
    else if (drain_last) resp_q <= SLVERR;
  end

endmodule

//--- common/axi_bridge_pkg.sv
`include "axi_bridge_consts.svh"

package axi_bridge_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // Shared by AW and AR, size and burst type are not carried
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [7:0]             len;
    logic [`AXI_USER_W-1:0] user;
  } axi_ax_t;

  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
    logic                   last;
  } axi_w_t;

  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    axi_resp_e              resp;
    logic [`AXI_USER_W-1:0] user;
  } axi_b_t;

  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_DATA_W-1:0] data;
    axi_resp_e              resp;
    logic                   last;
    logic [`AXI_USER_W-1:0] user;
  } axi_r_t;

  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    axi_resp_e              resp;
  } axil_r_t;

  typedef enum logic [2:0] {
    WR_IDLE,
    WR_FWD,        // Lite AW and W in flight
    WR_DRAIN,      // Burst beats swallowed until last
    WR_LITE_RESP,
    WR_RESP
  } wr_state_e;

  typedef enum logic [2:0] {
    RD_IDLE,
    RD_FWD,
    RD_LITE_DATA,
    RD_RESP,
    RD_ERR_BEATS   // One SLVERR beat per burst beat
  } rd_state_e;

endpackage

//--- common/axi_bridge_consts.svh
`ifndef AXI_BRIDGE_CONSTS_SVH
`define AXI_BRIDGE_CONSTS_SVH

// Byte address width on both the AXI and the AXI-Lite side
`define AXI_ADDR_W 16

`define AXI_DATA_W 32
`define AXI_STRB_W (`AXI_DATA_W / 8)

`define AXI_ID_W   4  // Reflected back unchanged in B and R
`define AXI_USER_W 2  // Reflected back unchanged in B and R

// Number of 32-bit registers in the bank
`define REG_COUNT 16

`endif
